// ==== filelist.f ====
hdl/lc3b_pkg.sv
hdl/regfile.sv
hdl/decode.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/branch_cc.sv
hdl/lc3b_exec_slice.sv
sim/tb_lc3b_exec_slice.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input lc3b_pkg::alu_ops aluop,
	input lc3b_pkg::lc3b_word a,
	input lc3b_pkg::lc3b_word b,
	output lc3b_pkg::lc3b_word f
);

logic [3:0] shamt;

assign shamt = b[3:0];

always_comb begin
	case (aluop)
		lc3b_pkg::alu_add:
			f = a + b;
		lc3b_pkg::alu_and:
			f = a & b;
		lc3b_pkg::alu_not:
			f = ~a;
		lc3b_pkg::alu_sll:
			f = a << shamt;
		lc3b_pkg::alu_srl:
			f = a >> shamt;
		lc3b_pkg::alu_sra:
			f = $signed(a) >>> shamt; // sign fill
		default:
			f = a; // pass for jmp and jsrr
	endcase
end

endmodule

// ==== hdl/branch_cc.sv ====
`timescale 1ns/1ps

module branch_cc (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_pkg::ID_EX id_ex,
	input lc3b_pkg::lc3b_word result,
	output lc3b_pkg::redirect_t redirect
);

logic [2:0] cc; // n z p
logic [2:0] cc_next;
logic br_taken;

always_comb begin
	if (result[15])
		cc_next = 3'b100;
	else if (result == '0)
		cc_next = 3'b010;
	else
		cc_next = 3'b001;
end

always_ff @(posedge clk) begin
	if (reset)
		cc <= lc3b_pkg::CC_Z;
	else if (id_ex.ctrl.load_cc && !stall)
		cc <= cc_next;
end

// nzp of 000 never matches, so that br acts as a nop
assign br_taken = id_ex.ctrl.is_branch && |(id_ex.instr.off.nzp & cc);

assign redirect.load = br_taken || (id_ex.ctrl.pcmux_sel == lc3b_pkg::PCMUX_ALU);
assign redirect.target = result;

cc_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(cc));

endmodule

// ==== hdl/decode.sv ====
`timescale 1ns/1ps

module decode (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_pkg::IF_ID if_id,
	output lc3b_pkg::lc3b_reg src_a,
	output lc3b_pkg::lc3b_reg src_b,
	input lc3b_pkg::lc3b_word reg_a,
	input lc3b_pkg::lc3b_word reg_b,
	output lc3b_pkg::ID_EX id_ex
);

lc3b_pkg::lc3b_instr instr;
lc3b_pkg::control_word ctrl;
logic [3:0] destreg;
lc3b_pkg::ID_EX id_ex_next;

assign instr = if_id.instr;
assign src_a = instr.rf.sr1; // also baser

always_comb begin
	src_b = instr.rf.sr2;
	if (instr.rf.opcode inside {lc3b_pkg::op_str, lc3b_pkg::op_stb, lc3b_pkg::op_sti})
		src_b = instr.off.nzp; // store source sits in the dr field
end

always_comb begin
	ctrl.srca_pc = 1'b0;
	ctrl.srcb_sel = lc3b_pkg::srcb_reg;
	ctrl.aluop = lc3b_pkg::alu_add;
	ctrl.load_regfile = 1'b0;
	ctrl.load_cc = 1'b0;
	ctrl.mem_read = 1'b0;
	ctrl.mem_write = 1'b0;
	ctrl.mem_byte = 1'b0;
	ctrl.isI = 1'b0;
	ctrl.is_branch = 1'b0;
	ctrl.pcmux_sel = lc3b_pkg::PCMUX_SEQ;
	ctrl.dest_r7 = 1'b0;
	destreg = lc3b_pkg::NO_DEST;

	case (instr.rf.opcode)
		lc3b_pkg::op_add, lc3b_pkg::op_and: begin
			ctrl.aluop = (instr.rf.opcode == lc3b_pkg::op_and) ?
				lc3b_pkg::alu_and : lc3b_pkg::alu_add;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			destreg = {1'b0, instr.rf.dr};
			if (instr.rf.steer)
				ctrl.srcb_sel = lc3b_pkg::srcb_imm5;
		end
		lc3b_pkg::op_not: begin
			ctrl.aluop = lc3b_pkg::alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			destreg = {1'b0, instr.rf.dr};
		end
		lc3b_pkg::op_shf: begin
			ctrl.srcb_sel = lc3b_pkg::srcb_imm4;
			if (!instr.rf.mid[1])
				ctrl.aluop = lc3b_pkg::alu_sll;
			else if (instr.rf.steer)
				ctrl.aluop = lc3b_pkg::alu_sra;
			else
				ctrl.aluop = lc3b_pkg::alu_srl;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			destreg = {1'b0, instr.rf.dr};
		end
		lc3b_pkg::op_lea: begin
			ctrl.srca_pc = 1'b1;
			ctrl.srcb_sel = lc3b_pkg::srcb_off9;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			destreg = {1'b0, instr.rf.dr};
		end
		lc3b_pkg::op_br: begin
			ctrl.srca_pc = 1'b1;
			ctrl.srcb_sel = lc3b_pkg::srcb_off9;
			ctrl.is_branch = 1'b1;
		end
		lc3b_pkg::op_jmp: begin
			ctrl.aluop = lc3b_pkg::alu_pass;
			ctrl.pcmux_sel = lc3b_pkg::PCMUX_ALU;
		end
		lc3b_pkg::op_jsr: begin
			ctrl.pcmux_sel = lc3b_pkg::PCMUX_ALU;
			ctrl.load_regfile = 1'b1;
			ctrl.dest_r7 = 1'b1;
			destreg = {1'b0, lc3b_pkg::LINK_REG};
			if (instr.off.nzp[2]) begin // jsr, pc relative
				ctrl.srca_pc = 1'b1;
				ctrl.srcb_sel = lc3b_pkg::srcb_off11;
			end else begin
				ctrl.aluop = lc3b_pkg::alu_pass; // jsrr
			end
		end
		lc3b_pkg::op_ldr, lc3b_pkg::op_ldi: begin
			ctrl.srcb_sel = lc3b_pkg::srcb_off6;
			ctrl.mem_read = 1'b1;
			ctrl.isI = (instr.rf.opcode == lc3b_pkg::op_ldi);
		end
		lc3b_pkg::op_ldb: begin
			ctrl.srcb_sel = lc3b_pkg::srcb_off6_raw;
			ctrl.mem_read = 1'b1;
			ctrl.mem_byte = 1'b1;
		end
		lc3b_pkg::op_str, lc3b_pkg::op_sti: begin
			ctrl.srcb_sel = lc3b_pkg::srcb_off6;
			ctrl.mem_write = 1'b1;
			ctrl.isI = (instr.rf.opcode == lc3b_pkg::op_sti);
		end
		lc3b_pkg::op_stb: begin
			ctrl.srcb_sel = lc3b_pkg::srcb_off6_raw;
			ctrl.mem_write = 1'b1;
			ctrl.mem_byte = 1'b1;
		end
		default: ; // rti and trap leave a bubble
	endcase
end

always_comb begin
	id_ex_next.pc = if_id.pc;
	id_ex_next.instr = if_id.instr;
	id_ex_next.srca = reg_a;
	id_ex_next.srcb = reg_b;
	id_ex_next.destreg = destreg;
	id_ex_next.ctrl = ctrl;
end

always_ff @(posedge clk) begin
	if (reset) begin
		id_ex.ctrl <= '0; // bubble
		id_ex.destreg <= lc3b_pkg::NO_DEST;
	end else if (!stall) begin
		id_ex <= id_ex_next;
	end
end

dest_marked: assert property (@(posedge clk) disable iff (reset)
	!id_ex.ctrl.load_regfile |-> id_ex.destreg[3]);

endmodule

// ==== hdl/lc3b_exec_slice.sv ====
`timescale 1ns/1ps

module lc3b_exec_slice (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_pkg::IF_ID if_id,
	output lc3b_pkg::wb_t wb,
	output lc3b_pkg::mem_req_t mem_req,
	output lc3b_pkg::redirect_t redirect
);

lc3b_pkg::lc3b_reg src_a;
lc3b_pkg::lc3b_reg src_b;
lc3b_pkg::lc3b_word reg_a;
lc3b_pkg::lc3b_word reg_b;
lc3b_pkg::ID_EX id_ex;
lc3b_pkg::lc3b_word opa;
lc3b_pkg::lc3b_word opb;
lc3b_pkg::lc3b_word alu_f;
lc3b_pkg::wb_t wb_next;
lc3b_pkg::wb_t rf_wb;
lc3b_pkg::mem_req_t mem_req_next;
lc3b_pkg::redirect_t redirect_next;

decode decode_i (.clk, .reset, .stall, .if_id, .src_a, .src_b, .reg_a, .reg_b, .id_ex);

regfile regfile_i (.clk, .reset, .wb(rf_wb), .src_a, .src_b, .reg_a, .reg_b);

operand_select operand_select_i (.id_ex, .opa, .opb);

alu alu_i (.aluop(id_ex.ctrl.aluop), .a(opa), .b(opb), .f(alu_f));

branch_cc branch_cc_i (.clk, .reset, .stall, .id_ex, .result(alu_f), .redirect(redirect_next));

assign wb_next.we = id_ex.ctrl.load_regfile;
assign wb_next.dest = id_ex.destreg[2:0];
assign wb_next.data = id_ex.ctrl.dest_r7 ? (id_ex.pc + lc3b_pkg::PC_INC) : alu_f;

// register file takes the result at the same edge as the output register
always_comb begin
	rf_wb = wb_next;
	rf_wb.we = wb_next.we && !stall;
end

assign mem_req_next.read = id_ex.ctrl.mem_read;
assign mem_req_next.write = id_ex.ctrl.mem_write;
assign mem_req_next.is_byte = id_ex.ctrl.mem_byte;
assign mem_req_next.indirect = id_ex.ctrl.isI;
assign mem_req_next.addr = alu_f;
assign mem_req_next.wdata = id_ex.srcb;

always_ff @(posedge clk) begin
	if (reset) begin
		wb.we <= 1'b0;
		mem_req.read <= 1'b0;
		mem_req.write <= 1'b0;
		redirect.load <= 1'b0;
	end else if (!stall) begin
		wb <= wb_next;
		mem_req <= mem_req_next;
		redirect <= redirect_next;
	end
end

endmodule

// ==== hdl/lc3b_pkg.sv ====
package lc3b_pkg;

localparam int WORD_W = 16;
localparam int REG_W = 3;
localparam int NUM_REGS = 8;
localparam logic [3:0] NO_DEST = 4'b1000; // bit 3 marks an unused register field
localparam logic [2:0] LINK_REG = 3'd7;
localparam logic [15:0] PC_INC = 16'd2;
localparam logic [1:0] PCMUX_SEQ = 2'b00;
localparam logic [1:0] PCMUX_ALU = 2'b01; // jump to alu result
localparam logic [2:0] CC_Z = 3'b010; // codes are {n, z, p}

typedef logic [WORD_W-1:0] lc3b_word;
typedef logic [REG_W-1:0] lc3b_reg;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass,
	alu_sll,
	alu_srl,
	alu_sra
} alu_ops;

typedef enum logic [2:0] {
	srcb_reg      = 3'b000,
	srcb_imm5     = 3'b001,
	srcb_off6     = 3'b010, // shifted left one
	srcb_off9     = 3'b011, // shifted left one
	srcb_off6_raw = 3'b100, // byte access, no shift
	srcb_imm4     = 3'b101, // shift amount
	srcb_off11    = 3'b110  // shifted left one
} srcb_sel_t;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dr;
	lc3b_reg sr1;
	logic steer; // imm select, or arithmetic flag for shf
	logic [1:0] mid; // upper imm5 bits, bit 1 is shift direction
	lc3b_reg sr2;
} instr_reg_t;

typedef struct packed {
	lc3b_opcode opcode;
	logic [2:0] nzp; // nzp for br, dr or sr for the rest
	lc3b_reg baser;
	logic [5:0] off6; // low part of offset9 together with baser
} instr_off_t;

typedef union packed {
	instr_reg_t rf;
	instr_off_t off;
} lc3b_instr;

typedef struct packed {
	logic srca_pc;
	srcb_sel_t srcb_sel;
	alu_ops aluop;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic mem_byte;
	logic isI;
	logic is_branch;
	logic [1:0] pcmux_sel;
	logic dest_r7;
} control_word;

typedef struct packed {
	lc3b_word pc;
	lc3b_instr instr;
} IF_ID;

typedef struct packed {
	lc3b_word pc;
	lc3b_instr instr;
	lc3b_word srca;
	lc3b_word srcb;
	logic [3:0] destreg;
	control_word ctrl;
} ID_EX;

typedef struct packed {
	logic we;
	lc3b_reg dest;
	lc3b_word data;
} wb_t;

typedef struct packed {
	logic read;
	logic write;
	logic is_byte;
	logic indirect;
	lc3b_word addr;
	lc3b_word wdata;
} mem_req_t;

typedef struct packed {
	logic load;
	lc3b_word target;
} redirect_t;

endpackage

// ==== hdl/operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
	input lc3b_pkg::ID_EX id_ex,
	output lc3b_pkg::lc3b_word opa,
	output lc3b_pkg::lc3b_word opb
);

logic [4:0] imm5;
logic [3:0] imm4;
logic [5:0] off6;
logic [8:0] off9;
logic [10:0] off11;

assign imm5 = {id_ex.instr.rf.mid, id_ex.instr.rf.sr2};
assign imm4 = {id_ex.instr.rf.mid[0], id_ex.instr.rf.sr2};
assign off6 = id_ex.instr.off.off6;
assign off9 = {id_ex.instr.off.baser, id_ex.instr.off.off6};
assign off11 = {id_ex.instr.off.nzp[1:0], off9};

assign opa = id_ex.ctrl.srca_pc ? (id_ex.pc + lc3b_pkg::PC_INC) : id_ex.srca;

always_comb begin
	case (id_ex.ctrl.srcb_sel)
		lc3b_pkg::srcb_imm5:
			opb = {{11{imm5[4]}}, imm5};
		lc3b_pkg::srcb_off6:
			opb = {{9{off6[5]}}, off6, 1'b0};
		lc3b_pkg::srcb_off9:
			opb = {{6{off9[8]}}, off9, 1'b0};
		lc3b_pkg::srcb_off6_raw:
			opb = {{10{off6[5]}}, off6};
		lc3b_pkg::srcb_imm4:
			opb = {12'b0, imm4};
		lc3b_pkg::srcb_off11:
			opb = {{4{off11[10]}}, off11, 1'b0};
		default:
			opb = id_ex.srcb; // register operand
	endcase
end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic reset,
	input lc3b_pkg::wb_t wb,
	input lc3b_pkg::lc3b_reg src_a,
	input lc3b_pkg::lc3b_reg src_b,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b
);

lc3b_pkg::lc3b_word regs [lc3b_pkg::NUM_REGS];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < lc3b_pkg::NUM_REGS; i++) begin
			regs[i] <= '0;
		end
	end else if (wb.we) begin
		regs[wb.dest] <= wb.data;
	end
end

// write-through so the next instruction sees the result without forwarding
always_comb begin
	reg_a = regs[src_a];
	if (wb.we && (wb.dest == src_a))
		reg_a = wb.data;
end

always_comb begin
	reg_b = regs[src_b];
	if (wb.we && (wb.dest == src_b))
		reg_b = wb.data;
end

wb_data_known: assert property (@(posedge clk) disable iff (reset)
	wb.we |-> !$isunknown(wb.data));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_lc3b_exec_slice -o tb_sim -f filelist.f \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0

// ==== sim/tb_lc3b_exec_slice.sv ====
`timescale 1ns/1ps

module tb_lc3b_exec_slice;

typedef struct packed {
	lc3b_pkg::wb_t wb;
	lc3b_pkg::mem_req_t mem;
	lc3b_pkg::redirect_t redirect;
} expect_t;

logic clk;
logic reset = 1'b1;
logic stall;
lc3b_pkg::IF_ID if_id;
lc3b_pkg::wb_t wb;
lc3b_pkg::mem_req_t mem_req;
lc3b_pkg::redirect_t redirect;

expect_t exp_next; // result of the instruction now in decode
expect_t exp_id;
expect_t exp_out; // what the outputs must show now
logic [15:0] shadow_regs [8];
logic [2:0] shadow_cc; // n z p
logic [15:0] pc;
int errors;
int wb_count;
int mem_count;
int redirect_count;
logic timed_out;

lc3b_exec_slice dut_i (.clk, .reset, .stall, .if_id, .wb, .mem_req, .redirect);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

function automatic logic [15:0] reg_form(lc3b_pkg::lc3b_opcode op, logic [2:0] f_a,
		logic [2:0] f_b, logic [5:0] low6);
	return {op, f_a, f_b, low6};
endfunction

function automatic logic [15:0] pc_form(lc3b_pkg::lc3b_opcode op, logic [2:0] f_a,
		logic [8:0] off9);
	return {op, f_a, off9};
endfunction

function automatic logic [15:0] idle_word();
	return {lc3b_pkg::op_trap, 12'h025}; // trap decodes to a bubble in this slice
endfunction

// ISA reference, evaluated in program order at issue
task automatic predict(input logic [15:0] ins, output expect_t e);
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] res;
	logic [15:0] npc;
	logic [3:0] amt;
	logic [2:0] dest;
	logic [3:0] op;
	op = ins[15:12];
	a = shadow_regs[ins[8:6]]; // sr1 or base register
	b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : shadow_regs[ins[2:0]];
	npc = pc + 16'd2;
	amt = ins[3:0];
	dest = ins[11:9];
	res = '0;
	e = '0;
	case (op)
		lc3b_pkg::op_add: res = a + b;
		lc3b_pkg::op_and: res = a & b;
		lc3b_pkg::op_not: res = ~a;
		lc3b_pkg::op_shf: begin
			res = ins[4] ? a >> amt : a << amt;
			if (ins[5:4] == 2'b11 && a[15])
				res = res | ~(16'hffff >> amt); // sign fill
		end
		lc3b_pkg::op_lea: res = npc + {{6{ins[8]}}, ins[8:0], 1'b0};
		lc3b_pkg::op_br: begin
			e.redirect.load = |(ins[11:9] & shadow_cc);
			e.redirect.target = npc + {{6{ins[8]}}, ins[8:0], 1'b0};
		end
		lc3b_pkg::op_jmp: begin
			e.redirect.load = 1'b1;
			e.redirect.target = a;
		end
		lc3b_pkg::op_jsr: begin
			e.redirect.load = 1'b1;
			e.redirect.target = ins[11] ? npc + {{4{ins[10]}}, ins[10:0], 1'b0} : a;
			res = npc;
			dest = 3'd7;
		end
		lc3b_pkg::op_ldr, lc3b_pkg::op_ldi, lc3b_pkg::op_str, lc3b_pkg::op_sti:
			e.mem.addr = a + {{9{ins[5]}}, ins[5:0], 1'b0};
		lc3b_pkg::op_ldb, lc3b_pkg::op_stb:
			e.mem.addr = a + {{10{ins[5]}}, ins[5:0]};
		default: ;
	endcase
	e.mem.read = op inside {lc3b_pkg::op_ldr, lc3b_pkg::op_ldb, lc3b_pkg::op_ldi};
	e.mem.write = op inside {lc3b_pkg::op_str, lc3b_pkg::op_stb, lc3b_pkg::op_sti};
	e.mem.is_byte = op inside {lc3b_pkg::op_ldb, lc3b_pkg::op_stb};
	e.mem.indirect = op inside {lc3b_pkg::op_ldi, lc3b_pkg::op_sti};
	e.mem.wdata = shadow_regs[ins[11:9]];
	if (op inside {lc3b_pkg::op_add, lc3b_pkg::op_and, lc3b_pkg::op_not, lc3b_pkg::op_shf,
			lc3b_pkg::op_lea, lc3b_pkg::op_jsr}) begin
		e.wb.we = 1'b1;
		e.wb.dest = dest;
		e.wb.data = res;
		shadow_regs[dest] = res;
	end
	if (op inside {lc3b_pkg::op_add, lc3b_pkg::op_and, lc3b_pkg::op_not, lc3b_pkg::op_shf,
			lc3b_pkg::op_lea}) begin
		if (res[15])
			shadow_cc = 3'b100;
		else if (res == 16'd0)
			shadow_cc = 3'b010;
		else
			shadow_cc = 3'b001;
	end
endtask

// present one instruction, optionally frozen by stall before it is taken
task automatic issue(input logic [15:0] ins, input int stall_cycles);
	expect_t e;
	predict(ins, e);
	if_id = {pc, ins};
	exp_next = e;
	if (e.wb.we)
		wb_count++;
	if (e.mem.read || e.mem.write)
		mem_count++;
	if (e.redirect.load)
		redirect_count++;
	pc = pc + 16'd2;
	stall = (stall_cycles > 0);
	repeat (stall_cycles) begin
		@(posedge clk);
		#1;
	end
	stall = 1'b0;
	@(posedge clk);
	#1;
	if_id = {pc, idle_word()};
	exp_next = '0;
endtask

always @(posedge clk) begin
	if (reset) begin
		exp_id <= '0;
		exp_out <= '0;
	end else if (!stall) begin
		exp_out <= exp_id;
		exp_id <= exp_next;
	end
end

wb_check: assert property (@(negedge clk) disable iff (reset)
	(wb.we === exp_out.wb.we) && (!exp_out.wb.we ||
	(wb.dest === exp_out.wb.dest && wb.data === exp_out.wb.data)))
	else begin
		errors++;
		$display("Fail %0t: writeback we=%0b r%0d=%h, expected we=%0b r%0d=%h", $time,
			wb.we, wb.dest, wb.data, exp_out.wb.we, exp_out.wb.dest, exp_out.wb.data);
	end

mem_check: assert property (@(negedge clk) disable iff (reset)
	(mem_req.read === exp_out.mem.read) && (mem_req.write === exp_out.mem.write) &&
	(!(exp_out.mem.read || exp_out.mem.write) || (mem_req.addr === exp_out.mem.addr &&
	mem_req.is_byte === exp_out.mem.is_byte && mem_req.indirect === exp_out.mem.indirect)) &&
	(!exp_out.mem.write || mem_req.wdata === exp_out.mem.wdata))
	else begin
		errors++;
		$display("Fail %0t: memory request rd=%0b wr=%0b addr=%h wdata=%h, expected %0b %0b %h %h",
			$time, mem_req.read, mem_req.write, mem_req.addr, mem_req.wdata,
			exp_out.mem.read, exp_out.mem.write, exp_out.mem.addr, exp_out.mem.wdata);
	end

redirect_check: assert property (@(negedge clk) disable iff (reset)
	(redirect.load === exp_out.redirect.load) &&
	(!exp_out.redirect.load || redirect.target === exp_out.redirect.target))
	else begin
		errors++;
		$display("Fail %0t: redirect load=%0b target=%h, expected load=%0b target=%h", $time,
			redirect.load, redirect.target, exp_out.redirect.load, exp_out.redirect.target);
	end

initial begin
	logic [31:0] rnd;
	lc3b_pkg::lc3b_opcode rop;
	logic [5:0] low6;
	int drain;
	rnd = $urandom(61015);
	stall = 1'b0;
	pc = 16'h3000;
	if_id = {pc, idle_word()};
	exp_next = '0;
	errors = 0;
	wb_count = 0;
	mem_count = 0;
	redirect_count = 0;
	timed_out = 1'b0;
	shadow_cc = 3'b010;
	for (int i = 0; i < 8; i++)
		shadow_regs[i] = '0;
	repeat (5) @(posedge clk);
	#1;
	reset = 1'b0;
	@(posedge clk);
	#1;
	issue(reg_form(lc3b_pkg::op_add, 3'd1, 3'd0, 6'b100101), 0); // r1 = 5
	issue(reg_form(lc3b_pkg::op_add, 3'd2, 3'd1, 6'b111101), 0); // back to back, -3
	issue(reg_form(lc3b_pkg::op_add, 3'd3, 3'd1, 6'b000010), 0);
	issue(reg_form(lc3b_pkg::op_and, 3'd4, 3'd3, 6'b100110), 0);
	issue(reg_form(lc3b_pkg::op_and, 3'd5, 3'd3, 6'b000100), 0);
	issue(reg_form(lc3b_pkg::op_not, 3'd6, 3'd5, 6'b111111), 0); // negative
	issue(reg_form(lc3b_pkg::op_shf, 3'd1, 3'd3, 6'b001100), 0); // lshf 12
	issue(reg_form(lc3b_pkg::op_shf, 3'd2, 3'd6, 6'b010100), 0); // rshfl 4
	issue(reg_form(lc3b_pkg::op_shf, 3'd3, 3'd6, 6'b110010), 0); // rshfa 2
	issue(pc_form(lc3b_pkg::op_br, 3'b100, 9'h004), 0); // taken on n
	issue(pc_form(lc3b_pkg::op_br, 3'b011, 9'h1fe), 0);
	issue(pc_form(lc3b_pkg::op_br, 3'b000, 9'h008), 0);
	issue(pc_form(lc3b_pkg::op_lea, 3'd4, 9'h1f8), 0);
	issue(pc_form(lc3b_pkg::op_br, 3'b001, 9'h010), 0);
	issue(reg_form(lc3b_pkg::op_and, 3'd0, 3'd0, 6'b100000), 0); // zero
	issue(pc_form(lc3b_pkg::op_br, 3'b010, 9'h1e0), 0);
	issue(pc_form(lc3b_pkg::op_br, 3'b101, 9'h001), 0);
	issue(reg_form(lc3b_pkg::op_jmp, 3'd0, 3'd3, 6'd0), 0);
	issue(reg_form(lc3b_pkg::op_jsr, 3'd0, 3'd1, 6'd0), 0); // jsrr
	issue({lc3b_pkg::op_jsr, 1'b1, 11'h7c0}, 0);
	issue(reg_form(lc3b_pkg::op_jmp, 3'd0, 3'd7, 6'd0), 0); // ret through fresh r7
	issue(reg_form(lc3b_pkg::op_add, 3'd5, 3'd7, 6'b100001), 0);
	issue(reg_form(lc3b_pkg::op_ldr, 3'd1, 3'd2, 6'h03), 0);
	issue(reg_form(lc3b_pkg::op_ldb, 3'd1, 3'd2, 6'h3b), 0);
	issue(reg_form(lc3b_pkg::op_ldi, 3'd6, 3'd3, 6'h3f), 0);
	issue(reg_form(lc3b_pkg::op_str, 3'd4, 3'd2, 6'h02), 0);
	issue(reg_form(lc3b_pkg::op_stb, 3'd5, 3'd6, 6'h1f), 0);
	issue(reg_form(lc3b_pkg::op_sti, 3'd0, 3'd5, 6'h20), 0);
	issue(reg_form(lc3b_pkg::op_rti, 3'd0, 3'd0, 6'd0), 0);
	issue(idle_word(), 0);
	issue(reg_form(lc3b_pkg::op_add, 3'd1, 3'd1, 6'b100001), 0);
	issue(reg_form(lc3b_pkg::op_add, 3'd2, 3'd1, 6'b000001), 4); // frozen behind producer
	issue(reg_form(lc3b_pkg::op_str, 3'd2, 3'd2, 6'h00), 3);
	issue(pc_form(lc3b_pkg::op_br, 3'b111, 9'h002), 2);
	for (int k = 0; k < 16; k++) begin
		rnd = $urandom;
		rop = rnd[0] ? lc3b_pkg::op_and : lc3b_pkg::op_add;
		low6 = rnd[1] ? {1'b1, rnd[8:4]} : {3'b000, rnd[11:9]};
		issue(reg_form(rop, rnd[14:12], rnd[17:15], low6), (rnd[20:18] == 3'd0) ? 2 : 0);
	end
	drain = 0;
	while (((exp_id != '0) || (exp_out != '0)) && (drain < 8)) begin
		@(posedge clk);
		#1;
		drain++;
	end
	if ((exp_id != '0) || (exp_out != '0)) begin
		timed_out = 1'b1;
		$display("Timeout: expected results still pending after 8 cycles");
	end
	@(negedge clk);
	#1;
	$display("checks: %0d writebacks, %0d memory requests, %0d redirects, %0d errors",
		wb_count, mem_count, redirect_count, errors);
	if (errors == 0 && !timed_out) begin
		$display("*** TEST PASSED ***");
	end else begin
		$display("*** TEST FAILED ***");
	end
	$finish;
end

endmodule
